// ==== entropy_arbiter.sv ====
/*
 * Round-robin sharing of one entropy source between two four-phase
 * consumers. A consumer must hold req until it sees its ack and may not
 * raise req again before that ack has fallen.
 */
`timescale 1ns/1ps
`default_nettype none

module entropy_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cond_req_i,
    output logic                  cond_ack_o,
    input  logic                  drbg_req_i,
    output logic                  drbg_ack_o,
    output logic                  src_req_o,
    input  logic                  src_ack_i,
    input  rng_cfg_pkg::raw_word_t src_word_i,
    output rng_cfg_pkg::raw_word_t word_o
);

    import rng_cfg_pkg::*;
    import rng_req_pkg::*;

    arb_state_t arb_state;
    logic       grant_drbg;
    logic       last_drbg;
    logic       ack_q;
    logic       granted_req;

    assign granted_req = grant_drbg ? drbg_req_i : cond_req_i;
    assign cond_ack_o  = ack_q && !grant_drbg;
    assign drbg_ack_o  = ack_q && grant_drbg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_state  <= ARB_IDLE;
            grant_drbg <= 1'b0;
            last_drbg  <= 1'b1;
            ack_q      <= 1'b0;
            src_req_o  <= 1'b0;
        end else begin
            case (arb_state)
                ARB_IDLE: begin
                    if (cond_req_i || drbg_req_i) begin
                        // The consumer served last yields to the other one
                        grant_drbg <= drbg_req_i && (!cond_req_i || !last_drbg);
                        src_req_o  <= 1'b1;
                        arb_state  <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (src_ack_i) begin
                        ack_q <= 1'b1;
                    end
                    if (ack_q && !granted_req) begin
                        src_req_o <= 1'b0;
                        arb_state <= ARB_RELEASE;
                    end
                end
                ARB_RELEASE: begin
                    if (!src_ack_i) begin
                        ack_q     <= 1'b0;
                        last_drbg <= grant_drbg;
                        arb_state <= ARB_IDLE;
                    end
                end
                default: arb_state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arb_state == ARB_WAIT_ACK && src_ack_i && !ack_q) begin
            word_o <= src_word_i;
        end
    end

    // An ack only goes to a consumer that is still requesting
    a_ack_to_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_q) |-> granted_req);

    // The source must have answered before its request is withdrawn
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(src_req_o) |-> $past(src_ack_i));

endmodule

`default_nettype wire

// ==== entropy_source.sv ====
/*
 * Noise cell model: a 64-bit Galois LFSR stepping every clock.
 * LFSR_SEED must be nonzero. A word is sampled on each req rise and
 * stays valid while ack is high.
 */
`timescale 1ns/1ps
`default_nettype none

module entropy_source #(
    parameter logic [63:0] LFSR_SEED = 64'h5a3c_96e1_0f7d_2b48
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ent_req_i,
    output logic        ent_ack_o,
    output logic [63:0] ent_word_o
);

    // Taps for x^64 + x^63 + x^61 + x^60 + 1
    localparam logic [63:0] LFSR_TAPS = 64'hd800_0000_0000_0000;

    logic [63:0] lfsr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr      <= LFSR_SEED;
            ent_ack_o <= 1'b0;
        end else begin
            lfsr      <= lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            // Ack follows req by one cycle in both directions
            ent_ack_o <= ent_req_i;
        end
    end

    // Sample once per handshake, on the req rise
    always_ff @(posedge clk) begin
        if (ent_req_i && !ent_ack_o) begin
            ent_word_o <= lfsr;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rng_cfg_pkg.sv
rng_req_pkg.sv
entropy_source.sv
entropy_arbiter.sv
seed_conditioner.sv
rand_drbg.sv
output_buffer.sv
trng_top.sv
trng_tb.sv

// ==== output_buffer.sv ====
/*
 * Seed queue, RDRAND buffer and host beat slicing.
 * OUTPUT_WIDTH must be 8 or 16; SEED_QUEUE_LEN a power of two of at least 2.
 * Host pins are registered, so the first beat comes two cycles after req.
 */
`timescale 1ns/1ps
`default_nettype none

module output_buffer #(
    parameter int OUTPUT_WIDTH   = rng_cfg_pkg::DEF_OUTPUT_WIDTH,
    parameter int SEED_QUEUE_LEN = rng_cfg_pkg::DEF_SEED_QUEUE_LEN
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     debug_i,
    input  logic                     triv_debug_i,
    input  logic                     ob_control_i,
    input  logic                     seed_valid_i,
    input  rng_cfg_pkg::seed_t       seed_i,
    output logic                     seed_ready_o,
    input  logic                     rand_valid_i,
    input  rng_cfg_pkg::rand_block_t rand_i,
    output logic                     rand_ready_o,
    input  logic                     triv_valid_i,
    input  rng_cfg_pkg::raw_word_t   triv_i,
    output logic                     triv_ready_o,
    input  rng_req_pkg::host_req_s   host_req_i,
    output logic                     ack_o,
    output logic [OUTPUT_WIDTH-1:0]  rand_word_o,
    output logic                     rand_valid_o
);

    import rng_cfg_pkg::*;
    import rng_req_pkg::*;

    localparam int SEED_SLICES = SEED_WIDTH / OUTPUT_WIDTH;
    localparam int RAND_SLICES = BLOCK_WIDTH / OUTPUT_WIDTH;
    localparam int SIDX_W      = $clog2(SEED_SLICES);
    localparam int RIDX_W      = $clog2(RAND_SLICES) + 1;
    localparam int PTR_W       = $clog2(SEED_QUEUE_LEN);
    localparam logic [PTR_W:0] QLEN = (PTR_W+1)'(SEED_QUEUE_LEN);

    seed_t              seed_q [SEED_QUEUE_LEN];
    logic [PTR_W:0]     head, tail, head_nxt, tail_nxt;
    logic               q_full, q_empty, q_wr, seed_last;
    logic [SIDX_W-1:0]  seed_idx;
    rand_block_t        rd_buf;
    rdrand_load_state_t rd_state;
    logic [RIDX_W-1:0]  rand_idx;
    logic               triv_half;
    logic               triv_eff;
    logic [5:0]         excess;
    ob_state_t          ob_state;
    host_req_s          req_q;
    logic [2:0]         beats_left;

    assign q_empty   = (head == tail);
    assign q_full    = (head[PTR_W] != tail[PTR_W]) && (head[PTR_W-1:0] == tail[PTR_W-1:0]);
    assign q_wr      = seed_valid_i && seed_ready_o;
    assign seed_last = (ob_state == OUTPUT_SEED) && rand_valid_o && (seed_idx == '1);
    assign head_nxt  = head + q_wr;
    assign tail_nxt  = tail + seed_last;

    assign triv_eff     = (excess >= TRIV_THRESHOLD) || triv_debug_i || (debug_i && ob_control_i);
    assign rand_ready_o = (rd_state == LOAD_DRBG);
    assign triv_ready_o = (rd_state == LOAD_TRIV);
    assign ack_o        = (ob_state == OUTPUT_DONE);

    always_ff @(posedge clk) begin
        if (q_wr) begin
            seed_q[head[PTR_W-1:0]] <= seed_i;
        end
        if (rd_state == LOAD_DRBG && rand_valid_i) begin
            rd_buf <= rand_i;
        end
        if (rd_state == LOAD_TRIV && triv_valid_i) begin
            rd_buf[RAW_WIDTH*triv_half +: RAW_WIDTH] <= triv_i;
        end
    end

    // Ready is registered from the next pointers, so a full queue stops the stream at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            seed_ready_o <= 1'b0;
        end else begin
            head         <= head_nxt;
            tail         <= tail_nxt;
            seed_ready_o <= (head_nxt - tail_nxt) != QLEN;
        end
    end

    // RDRAND buffer fill, mode chosen each time the buffer runs dry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state  <= BUF_INVALID;
            rand_idx  <= '0;
            triv_half <= 1'b0;
        end else begin
            if (ob_state == OUTPUT_RAND && rand_valid_o) begin
                rand_idx <= rand_idx + 1'b1;
            end
            case (rd_state)
                BUF_INVALID: begin
                    rand_idx  <= '0;
                    triv_half <= 1'b0;
                    rd_state  <= triv_eff ? LOAD_TRIV : LOAD_DRBG;
                end
                LOAD_DRBG: if (rand_valid_i) rd_state <= BUF_VALID;
                LOAD_TRIV: begin
                    if (triv_valid_i) begin
                        triv_half <= 1'b1;
                        if (triv_half) rd_state <= BUF_VALID;
                    end
                end
                BUF_VALID: if (rand_idx == RAND_SLICES) rd_state <= BUF_INVALID;
                default:   rd_state <= BUF_INVALID;
            endcase
        end
    end

    // Host beat FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ob_state   <= OUTPUT_IDLE;
            req_q      <= '0;
            beats_left <= '0;
            seed_idx   <= '0;
            excess     <= '0;
        end else begin
            req_q <= host_req_i;
            if (ob_state == OUTPUT_SEED && rand_valid_o) begin
                seed_idx <= seed_idx + 1'b1;
            end
            case (ob_state)
                OUTPUT_IDLE: begin
                    if (req_q.req) begin
                        beats_left <= 3'(((16 << req_q.req_type[1:0]) / OUTPUT_WIDTH) - 1);
                        if (req_q.req_type[2]) begin
                            ob_state <= OUTPUT_RAND;
                            if (excess != '1) excess <= excess + 1'b1;
                        end else begin
                            ob_state <= OUTPUT_SEED;
                            if (excess != '0) excess <= excess - 1'b1;
                        end
                    end
                end
                OUTPUT_SEED, OUTPUT_RAND: begin
                    if (rand_valid_o) begin
                        if (beats_left == '0) ob_state <= OUTPUT_DONE;
                        else beats_left <= beats_left - 1'b1;
                    end
                end
                OUTPUT_DONE: if (!req_q.req) ob_state <= OUTPUT_IDLE;
                default:     ob_state <= OUTPUT_IDLE;
            endcase
        end
    end

    always_comb begin
        rand_valid_o = 1'b0;
        rand_word_o  = '0;
        case (ob_state)
            OUTPUT_SEED: begin
                if (!q_empty) begin
                    rand_valid_o = 1'b1;
                    rand_word_o  = seed_q[tail[PTR_W-1:0]][OUTPUT_WIDTH*seed_idx +: OUTPUT_WIDTH];
                end
            end
            OUTPUT_RAND: begin
                if (rd_state == BUF_VALID && rand_idx < RAND_SLICES) begin
                    rand_valid_o = 1'b1;
                    rand_word_o  = rd_buf[OUTPUT_WIDTH*rand_idx +: OUTPUT_WIDTH];
                end
            end
            default: ;
        endcase
    end

    // Registered ready must agree with the pointer state
    a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
        q_wr |-> !q_full);

    // Beats only go out while the host still holds its request
    a_beat_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        rand_valid_o |-> req_q.req);

endmodule

`default_nettype wire

// ==== rand_drbg.sv ====
/*
 * Counter-mode generator with a 128-bit key, reseeded from two raw words
 * every RESEED_INTERVAL blocks. No block is made before the first reseed.
 * While the buffer is ready on the triv stream, raw words pass through unmixed.
 */
`timescale 1ns/1ps
`default_nettype none

module rand_drbg (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     ent_req_o,
    input  logic                     ent_ack_i,
    input  rng_cfg_pkg::raw_word_t   ent_word_i,
    output logic                     rand_valid_o,
    output rng_cfg_pkg::rand_block_t rand_o,
    input  logic                     rand_ready_i,
    output logic                     triv_valid_o,
    output rng_cfg_pkg::raw_word_t   triv_o,
    input  logic                     triv_ready_i
);

    import rng_cfg_pkg::*;

    localparam int CNT_W = $clog2(RESEED_INTERVAL + 1);

    rand_block_t      key;
    raw_word_t        ctr;
    logic [CNT_W-1:0] blk_cnt;
    logic             key_half;
    logic             fetch_triv;
    logic             need_key;
    logic             gen;
    rand_block_t      x;
    rand_block_t      y;
    rand_block_t      mix_blk;

    assign need_key = (blk_cnt == RESEED_INTERVAL);
    assign gen      = (!rand_valid_o || rand_ready_i) && !need_key;

    // Add and AND rounds give the nonlinearity
    always_comb begin
        x       = key ^ {ctr, ~ctr};
        y       = x + {x[RAW_WIDTH-1:0], x[BLOCK_WIDTH-1:RAW_WIDTH]};
        mix_blk = y ^ ({y[98:0], y[127:99]} & {y[56:0], y[127:57]}) ^ {y[16:0], y[127:17]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key          <= '0;
            ctr          <= '0;
            blk_cnt      <= CNT_W'(RESEED_INTERVAL);
            key_half     <= 1'b0;
            fetch_triv   <= 1'b0;
            ent_req_o    <= 1'b0;
            rand_valid_o <= 1'b0;
            triv_valid_o <= 1'b0;
        end else begin
            // Trivial words take priority over a pending reseed
            if (!ent_req_o && !ent_ack_i && !triv_valid_o && (triv_ready_i || need_key)) begin
                ent_req_o  <= 1'b1;
                fetch_triv <= triv_ready_i;
            end
            if (ent_req_o && ent_ack_i) begin
                ent_req_o <= 1'b0;
                if (fetch_triv) begin
                    triv_valid_o <= 1'b1;
                end else begin
                    key[RAW_WIDTH*key_half +: RAW_WIDTH] <=
                        key[RAW_WIDTH*key_half +: RAW_WIDTH] ^ ent_word_i;
                    key_half <= !key_half;
                    if (key_half) begin
                        blk_cnt <= '0;
                    end
                end
            end
            if (triv_valid_o && triv_ready_i) begin
                triv_valid_o <= 1'b0;
            end
            if (!rand_valid_o || rand_ready_i) begin
                rand_valid_o <= !need_key;
            end
            if (gen) begin
                ctr     <= ctr + 1'b1;
                blk_cnt <= blk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gen) begin
            rand_o <= mix_blk;
        end
        if (ent_req_o && ent_ack_i && fetch_triv) begin
            triv_o <= ent_word_i;
        end
    end

endmodule

`default_nettype wire

// ==== rng_cfg_pkg.sv ====
/*
 * Datapath widths and default sizes for the random number service.
 * The seed is four raw words wide and a DRBG block is two raw words wide;
 * the output buffer relies on both ratios.
 */
`default_nettype none

package rng_cfg_pkg;

    // Widths of the three data kinds
    parameter int RAW_WIDTH   = 64;
    parameter int SEED_WIDTH  = 4 * RAW_WIDTH;
    parameter int BLOCK_WIDTH = 2 * RAW_WIDTH;

    typedef logic [RAW_WIDTH-1:0]   raw_word_t;
    typedef logic [SEED_WIDTH-1:0]  seed_t;
    typedef logic [BLOCK_WIDTH-1:0] rand_block_t;

    // Defaults picked up by the top level
    parameter int DEF_OUTPUT_WIDTH   = 16;
    parameter int DEF_SEED_QUEUE_LEN = 8;

    // Excess RDRAND requests before the buffer falls back to raw words
    parameter int TRIV_THRESHOLD = 45;

    // DRBG blocks between two reseeds
    parameter int RESEED_INTERVAL = 16;

endpackage

`default_nettype wire

// ==== rng_req_pkg.sv ====
/*
 * Host request encoding and the state machine types.
 * Bit 2 of a request type selects RDRAND, bits 1:0 give the size
 * as 16 << n bits.
 */
`default_nettype none

package rng_req_pkg;

    typedef enum logic [2:0] {
        RDSEED_16 = 3'b000,
        RDSEED_32 = 3'b001,
        RDSEED_64 = 3'b010,
        RDRAND_16 = 3'b100,
        RDRAND_32 = 3'b101,
        RDRAND_64 = 3'b110
    } rand_req_t;

    typedef struct packed {
        logic      req;
        rand_req_t req_type;
    } host_req_s;

    typedef enum logic [1:0] {OUTPUT_IDLE, OUTPUT_SEED, OUTPUT_RAND, OUTPUT_DONE} ob_state_t;

    typedef enum logic [1:0] {BUF_INVALID, LOAD_DRBG, LOAD_TRIV, BUF_VALID} rdrand_load_state_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_WAIT_ACK, ARB_RELEASE} arb_state_t;

endpackage

`default_nettype wire

// ==== seed_conditioner.sv ====
/*
 * Folds four raw words into one 256-bit seed by rotate-and-XOR.
 * The accumulator carries over from seed to seed. No new entropy is
 * requested while a finished seed waits for the buffer.
 */
`timescale 1ns/1ps
`default_nettype none

module seed_conditioner (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   ent_req_o,
    input  logic                   ent_ack_i,
    input  rng_cfg_pkg::raw_word_t ent_word_i,
    output logic                   seed_valid_o,
    output rng_cfg_pkg::seed_t     seed_o,
    input  logic                   seed_ready_i
);

    import rng_cfg_pkg::*;

    logic [1:0] word_cnt;
    logic [1:0] prev_idx;
    raw_word_t  prev_lane;
    raw_word_t  mixed_lane;
    seed_t      acc;

    assign prev_idx   = word_cnt - 2'd1;
    assign prev_lane  = acc[RAW_WIDTH*prev_idx +: RAW_WIDTH];
    // Rotate the neighbour lane left by 13 before folding in
    assign mixed_lane = acc[RAW_WIDTH*word_cnt +: RAW_WIDTH] ^ ent_word_i
                      ^ {prev_lane[RAW_WIDTH-14:0], prev_lane[RAW_WIDTH-1:RAW_WIDTH-13]};
    assign seed_o     = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt     <= '0;
            ent_req_o    <= 1'b0;
            seed_valid_o <= 1'b0;
            acc          <= '0;
        end else begin
            if (!seed_valid_o && !ent_req_o && !ent_ack_i) begin
                ent_req_o <= 1'b1;
            end
            if (ent_req_o && ent_ack_i) begin
                ent_req_o                              <= 1'b0;
                acc[RAW_WIDTH*word_cnt +: RAW_WIDTH] <= mixed_lane;
                word_cnt                               <= word_cnt + 2'd1;
                if (word_cnt == 2'd3) begin
                    seed_valid_o <= 1'b1;
                end
            end
            if (seed_valid_o && seed_ready_i) begin
                seed_valid_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== trng_tb.sv ====
/*
 * Table-driven testbench for trng_top with 16-bit beats.
 * Each table entry runs one four-phase host request. Beat counts, handshake
 * order and result freshness are checked against the entry.
 */
`timescale 1ns/1ps
`default_nettype none

module trng_tb;

    import rng_req_pkg::*;

    localparam int NUM_TESTS = 16;
    localparam int BEAT_W    = 16;
    localparam int ACK_LIMIT = 1000;
    localparam int LONG_GAP  = 600;

    typedef struct packed {
        rand_req_t  req_type;
        logic       debug;
        logic       triv_debug;
        logic       ob_control;
        logic [2:0] exp_beats;
        logic [9:0] gap;
        logic       burst;
    } test_entry_s;

    logic              clk;
    logic              rst_n;
    logic              debug_i;
    logic              triv_debug_i;
    logic              ob_control_i;
    host_req_s         host_req_i;
    logic              ack_o;
    logic [BEAT_W-1:0] rand_word_o;
    logic              rand_valid_o;

    test_entry_s       table_q [NUM_TESTS];
    int                errors;
    int                checks;
    int                err_before;
    int                gap;
    int                idx;
    int unsigned       seed_init;
    logic [63:0]       last_seed64;
    logic [63:0]       last_rand64;
    logic              have_seed64;
    logic              have_rand64;

    trng_top #(
        .OUTPUT_WIDTH(BEAT_W),
        .SEED_QUEUE_LEN(rng_cfg_pkg::DEF_SEED_QUEUE_LEN),
        .LFSR_SEED(64'h5a3c_96e1_0f7d_2b48)
    ) u_dut (
        .clk(clk), .rst_n(rst_n),
        .debug_i(debug_i), .triv_debug_i(triv_debug_i), .ob_control_i(ob_control_i),
        .host_req_i(host_req_i),
        .ack_o(ack_o), .rand_word_o(rand_word_o), .rand_valid_o(rand_valid_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic test_entry_s make_entry(input rand_req_t t, input logic dbg,
                                               input logic tdbg, input logic ctl,
                                               input logic [2:0] beats,
                                               input logic [9:0] gap_cycles,
                                               input logic burst);
        test_entry_s e;
        e.req_type   = t;
        e.debug      = dbg;
        e.triv_debug = tdbg;
        e.ob_control = ctl;
        e.exp_beats  = beats;
        e.gap        = gap_cycles;
        e.burst      = burst;
        return e;
    endfunction

    function automatic string type_name(input rand_req_t t);
        case (t)
            RDSEED_16: return "RDSEED_16";
            RDSEED_32: return "RDSEED_32";
            RDSEED_64: return "RDSEED_64";
            RDRAND_16: return "RDRAND_16";
            RDRAND_32: return "RDRAND_32";
            RDRAND_64: return "RDRAND_64";
            default:   return "unknown";
        endcase
    endfunction

    // Beats are width / 16; a gap of zero means a short random gap
    task automatic load_table();
        table_q[0]  = make_entry(RDSEED_16, 1'b0, 1'b0, 1'b0, 3'd1, 10'd0, 1'b0);
        table_q[1]  = make_entry(RDSEED_32, 1'b0, 1'b0, 1'b0, 3'd2, 10'd0, 1'b0);
        table_q[2]  = make_entry(RDSEED_64, 1'b0, 1'b0, 1'b0, 3'd4, 10'd0, 1'b0);
        table_q[3]  = make_entry(RDRAND_16, 1'b0, 1'b0, 1'b0, 3'd1, 10'd0, 1'b0);
        table_q[4]  = make_entry(RDRAND_32, 1'b0, 1'b0, 1'b0, 3'd2, 10'd0, 1'b0);
        table_q[5]  = make_entry(RDRAND_64, 1'b0, 1'b0, 1'b0, 3'd4, 10'd0, 1'b0);
        table_q[6]  = make_entry(RDSEED_64, 1'b0, 1'b0, 1'b0, 3'd4, 10'd0, 1'b0);
        table_q[7]  = make_entry(RDRAND_64, 1'b0, 1'b0, 1'b0, 3'd4, 10'd0, 1'b0);
        // Long idle gap lets the seed queue fill up
        table_q[8]  = make_entry(RDSEED_64, 1'b0, 1'b0, 1'b0, 3'd4, LONG_GAP, 1'b1);
        table_q[9]  = make_entry(RDSEED_64, 1'b0, 1'b0, 1'b0, 3'd4, 10'd0, 1'b0);
        // Debug override with trivial mode forced
        table_q[10] = make_entry(RDRAND_64, 1'b1, 1'b1, 1'b1, 3'd4, 10'd0, 1'b0);
        table_q[11] = make_entry(RDRAND_16, 1'b1, 1'b1, 1'b1, 3'd1, 10'd0, 1'b0);
        table_q[12] = make_entry(RDRAND_32, 1'b1, 1'b1, 1'b1, 3'd2, 10'd0, 1'b0);
        table_q[13] = make_entry(RDRAND_64, 1'b1, 1'b1, 1'b1, 3'd4, 10'd0, 1'b0);
        table_q[14] = make_entry(RDSEED_32, 1'b0, 1'b0, 1'b0, 3'd2, 10'd0, 1'b0);
        table_q[15] = make_entry(RDRAND_64, 1'b0, 1'b0, 1'b0, 3'd4, 10'd0, 1'b0);
    endtask

    // Sample and drive 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_gap(input int cycles, input int tnum);
        for (int i = 0; i < cycles; i++) begin
            step_cycle();
            checks++;
            if (rand_valid_o || ack_o) begin
                errors++;
                $display("test %0d: rand_valid_o or ack_o high with no open request", tnum);
            end
        end
    endtask

    task automatic check_fresh(input int tnum, input logic [63:0] result,
                               inout logic [63:0] last, inout logic have);
        checks++;
        if (have && result == last) begin
            errors++;
            $display("ERR test %0d rand_word_o got %h same as previous %h", tnum, result, last);
        end
        last = result;
        have = 1'b1;
    endtask

    task automatic run_request(input int tnum);
        test_entry_s e;
        logic [63:0] result;
        int          beats;
        int          first_beat;
        int          last_beat;
        int          cyc;
        int          hold;
        logic        prev_valid;
        logic        done;
        e          = table_q[tnum];
        result     = '0;
        beats      = 0;
        first_beat = 0;
        last_beat  = 0;
        cyc        = 0;
        prev_valid = 1'b0;
        done       = 1'b0;
        host_req_i.req_type = e.req_type;
        host_req_i.req      = 1'b1;
        while (!done && cyc < ACK_LIMIT) begin
            step_cycle();
            cyc++;
            if (rand_valid_o) begin
                if (beats < 4) result[BEAT_W*beats +: BEAT_W] = rand_word_o;
                if (beats == 0) first_beat = cyc;
                last_beat = cyc;
                beats++;
            end
            if (ack_o) begin
                done = 1'b1;
                checks++;
                if (rand_valid_o || !prev_valid) begin
                    errors++;
                    $display("test %0d: ack_o did not rise right after the last beat", tnum);
                end
            end
            prev_valid = rand_valid_o;
        end
        if (!done) begin
            errors++;
            $display("test %0d: timeout, ack_o did not rise within %0d cycles", tnum, ACK_LIMIT);
        end else begin
            // ack_o must stay up until req drops
            hold = $urandom % 4;
            for (int i = 0; i < hold; i++) begin
                step_cycle();
                checks++;
                if (!ack_o || rand_valid_o) begin
                    errors++;
                    $display("test %0d: ack_o fell or a beat came while req was high", tnum);
                end
            end
        end
        host_req_i.req = 1'b0;
        cyc = 0;
        while (ack_o && cyc < 20) begin
            step_cycle();
            cyc++;
            if (rand_valid_o) begin
                errors++;
                $display("test %0d: beat on rand_valid_o after ack_o", tnum);
            end
        end
        if (ack_o) begin
            errors++;
            $display("test %0d: ack_o did not fall after req dropped", tnum);
        end
        checks++;
        if (beats != e.exp_beats) begin
            errors++;
            $display("ERR test %0d rand_valid_o beats got %0h expected %0h",
                     tnum, beats, e.exp_beats);
        end
        if (e.burst && last_beat - first_beat != beats - 1) begin
            errors++;
            $display("test %0d: the four seed beats were not in consecutive cycles", tnum);
        end
        if (e.exp_beats == 3'd4 || e.triv_debug) begin
            checks++;
            if (result == '0) begin
                errors++;
                $display("ERR test %0d rand_word_o got %h expected nonzero", tnum, result);
            end
        end
        if (e.req_type == RDSEED_64) check_fresh(tnum, result, last_seed64, have_seed64);
        if (e.req_type == RDRAND_64) check_fresh(tnum, result, last_rand64, have_rand64);
    endtask

    initial begin
        seed_init    = $urandom(32'h976117fe);
        errors       = 0;
        checks       = 0;
        last_seed64  = '0;
        last_rand64  = '0;
        have_seed64  = 1'b0;
        have_rand64  = 1'b0;
        rst_n        = 1'b0;
        debug_i      = 1'b0;
        triv_debug_i = 1'b0;
        ob_control_i = 1'b0;
        host_req_i   = '0;
        load_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs stay quiet after reset with no request
        err_before = errors;
        idle_gap(20, -1);
        $display("reset idle check: %s", (errors == err_before) ? "ok" : "failed");

        for (idx = 0; idx < NUM_TESTS; idx++) begin
            err_before   = errors;
            gap          = (table_q[idx].gap != 0) ? table_q[idx].gap : 1 + ($urandom % 12);
            debug_i      = table_q[idx].debug;
            triv_debug_i = table_q[idx].triv_debug;
            ob_control_i = table_q[idx].ob_control;
            idle_gap(gap, idx);
            run_request(idx);
            $display("test %0d %s: %s", idx, type_name(table_q[idx].req_type),
                     (errors == err_before) ? "ok" : "failed");
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(NUM_TESTS * 2000);
        $display("watchdog: run did not finish within %0d ns", NUM_TESTS * 2000);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== trng_top.sv ====
/*
 * Random number service top level. Everything runs on clk.
 * The host uses a four-phase req/ack handshake with one beat per cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module trng_top #(
    parameter int          OUTPUT_WIDTH   = rng_cfg_pkg::DEF_OUTPUT_WIDTH,
    parameter int          SEED_QUEUE_LEN = rng_cfg_pkg::DEF_SEED_QUEUE_LEN,
    parameter logic [63:0] LFSR_SEED      = 64'h5a3c_96e1_0f7d_2b48
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    debug_i,
    input  logic                    triv_debug_i,
    input  logic                    ob_control_i,
    input  rng_req_pkg::host_req_s  host_req_i,
    output logic                    ack_o,
    output logic [OUTPUT_WIDTH-1:0] rand_word_o,
    output logic                    rand_valid_o
);

    import rng_cfg_pkg::*;

    logic        src_req, src_ack;
    raw_word_t   src_word, arb_word;
    logic        cond_req, cond_ack, drbg_req, drbg_ack;
    logic        seed_valid, seed_ready;
    seed_t       seed;
    logic        rand_valid, rand_ready;
    rand_block_t rand_blk;
    logic        triv_valid, triv_ready;
    raw_word_t   triv_word;

    entropy_source #(.LFSR_SEED(LFSR_SEED)) u_src (
        .clk(clk), .rst_n(rst_n),
        .ent_req_i(src_req), .ent_ack_o(src_ack), .ent_word_o(src_word)
    );

    entropy_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .cond_req_i(cond_req), .cond_ack_o(cond_ack),
        .drbg_req_i(drbg_req), .drbg_ack_o(drbg_ack),
        .src_req_o(src_req), .src_ack_i(src_ack),
        .src_word_i(src_word), .word_o(arb_word)
    );

    seed_conditioner u_cond (
        .clk(clk), .rst_n(rst_n),
        .ent_req_o(cond_req), .ent_ack_i(cond_ack), .ent_word_i(arb_word),
        .seed_valid_o(seed_valid), .seed_o(seed), .seed_ready_i(seed_ready)
    );

    rand_drbg u_drbg (
        .clk(clk), .rst_n(rst_n),
        .ent_req_o(drbg_req), .ent_ack_i(drbg_ack), .ent_word_i(arb_word),
        .rand_valid_o(rand_valid), .rand_o(rand_blk), .rand_ready_i(rand_ready),
        .triv_valid_o(triv_valid), .triv_o(triv_word), .triv_ready_i(triv_ready)
    );

    output_buffer #(
        .OUTPUT_WIDTH(OUTPUT_WIDTH),
        .SEED_QUEUE_LEN(SEED_QUEUE_LEN)
    ) u_obuf (
        .clk(clk), .rst_n(rst_n),
        .debug_i(debug_i), .triv_debug_i(triv_debug_i), .ob_control_i(ob_control_i),
        .seed_valid_i(seed_valid), .seed_i(seed), .seed_ready_o(seed_ready),
        .rand_valid_i(rand_valid), .rand_i(rand_blk), .rand_ready_o(rand_ready),
        .triv_valid_i(triv_valid), .triv_i(triv_word), .triv_ready_o(triv_ready),
        .host_req_i(host_req_i),
        .ack_o(ack_o), .rand_word_o(rand_word_o), .rand_valid_o(rand_valid_o)
    );

endmodule

`default_nettype wire
